/* hdl/ctrl_params.svh */
// controller widths and exception cause codes
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

//////////////////////////////
// field widths
//////////////////////////////

// interrupt id from the interrupt controller
`define CTRL_IRQ_ID_W 5

// mcause field, one bit wider than the irq id
`define CTRL_CAUSE_W 6

// fetch stage pc selector
`define CTRL_PC_MUX_W 3

// exception vector selector
`define CTRL_EXC_MUX_W 2

//////////////////////////////
// cause codes
//////////////////////////////

// illegal instruction exception
`define CTRL_CAUSE_ILLEGAL 2

// ebreak
`define CTRL_CAUSE_BREAKPOINT 3

// environment call, ored with the current privilege level
// which gives 8 from user mode and 11 from machine mode
`define CTRL_CAUSE_ECALL_BASE 8

`endif

/* hdl/ctrl_pkg.sv */
// controller types: fsm states, selectors, privilege, decode flags, events, trap outputs
`include "ctrl_params.svh"

package ctrl_pkg;

  // controller fsm states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // fetch stage pc source
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXCEPTION,
    PC_ERET
  } pc_sel_e;

  // exception vector offset select
  typedef enum logic [`CTRL_EXC_MUX_W-1:0] {
    EXC_PC_ILLINSN,
    EXC_PC_ECALL,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // raw flags from the id stage decoder
  typedef struct packed {
    logic instr_valid;
    logic branch_set;
    logic jump_set;
    logic mret;
    logic ecall;
    logic pipe_flush;
    logic ebrk;
    logic illegal;
    logic csr_status;
    logic multicycle;
    logic branch_in_id;
  } decode_flags_t;

  // one winning event per decode cycle
  typedef enum logic [2:0] {
    EV_NONE,
    EV_BRANCH,
    EV_JUMP,
    EV_FLUSH,
    EV_IRQ,
    EV_KILL
  } decode_event_e;

  // flush causes, highest priority first
  typedef enum logic [2:0] {
    FL_ECALL,
    FL_ILLEGAL,
    FL_MRET,
    FL_EBRK,
    FL_CSR,
    FL_PIPE
  } flush_kind_e;

  // fsm redirect action handed to the trap encoder
  typedef enum logic [2:0] {
    RD_NONE,
    RD_BOOT,
    RD_JUMP,
    RD_IRQ,
    RD_FLUSH
  } redirect_e;

  // pc redirect, cause and csr strobes towards if stage and csr file
  typedef struct packed {
    logic                     pc_set;
    pc_sel_e                  pc_mux;
    exc_pc_sel_e              exc_pc_mux;
    logic [`CTRL_CAUSE_W-1:0] exc_cause;
    logic [`CTRL_CAUSE_W-1:0] csr_cause;
    logic                     csr_save_if;
    logic                     csr_save_id;
    logic                     csr_save_cause;
    logic                     csr_restore_mret;
    logic                     irq_ack;
    logic                     exc_ack;
  } trap_out_t;

endpackage

/* hdl/ctrl_event_classify.sv */
// decode event classifier: prioritizes decoder flags and interrupt request into one event
module ctrl_event_classify (
  input  ctrl_pkg::decode_flags_t decode_i,
  input  logic                    irq_req_i,
  input  logic                    m_ie_i,
  output ctrl_pkg::decode_event_e event_o,
  output ctrl_pkg::flush_kind_e   flush_kind_o
);

  // any instruction that needs the pipe emptied
  logic flush_any;
  // interrupt not blocked by the instruction in id
  logic irq_ok;

  assign flush_any = decode_i.ecall | decode_i.illegal | decode_i.mret |
                     decode_i.ebrk | decode_i.csr_status | decode_i.pipe_flush;

  // a multicycle op or a branch in id must finish before an irq cuts in
  assign irq_ok = irq_req_i & ~decode_i.multicycle & ~decode_i.branch_in_id;

  //////////////////////////////
  // event priority
  //////////////////////////////

  always_comb begin
    event_o = ctrl_pkg::EV_NONE;
    if (decode_i.instr_valid) begin
      if (decode_i.branch_set) begin
        event_o = ctrl_pkg::EV_BRANCH;
      end else if (decode_i.jump_set) begin
        event_o = ctrl_pkg::EV_JUMP;
      end else if (flush_any) begin
        event_o = ctrl_pkg::EV_FLUSH;
      end else if (irq_ok && m_ie_i) begin
        event_o = ctrl_pkg::EV_IRQ;
      end else if (irq_ok) begin
        // masked request, only hint the exception logic
        event_o = ctrl_pkg::EV_KILL;
      end
    end else if (irq_req_i && m_ie_i) begin
      // empty id stage, nothing can block the interrupt
      event_o = ctrl_pkg::EV_IRQ;
    end
  end

  //////////////////////////////
  // flush cause priority
  //////////////////////////////

  always_comb begin
    if (decode_i.ecall) begin
      flush_kind_o = ctrl_pkg::FL_ECALL;
    end else if (decode_i.illegal) begin
      flush_kind_o = ctrl_pkg::FL_ILLEGAL;
    end else if (decode_i.mret) begin
      flush_kind_o = ctrl_pkg::FL_MRET;
    end else if (decode_i.ebrk) begin
      flush_kind_o = ctrl_pkg::FL_EBRK;
    end else if (decode_i.csr_status) begin
      flush_kind_o = ctrl_pkg::FL_CSR;
    end else begin
      // pipe flush, also the idle value when no cause is set
      flush_kind_o = ctrl_pkg::FL_PIPE;
    end
  end

endmodule

/* hdl/ctrl_fsm.sv */
// controller fsm: state register, next state, fetch, halt and busy controls
module ctrl_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_enable_i,
  input  logic                    id_ready_i,
  input  logic                    irq_req_i,
  input  logic                    instr_valid_i,
  input  logic                    illegal_i,
  input  ctrl_pkg::decode_event_e event_i,
  input  ctrl_pkg::flush_kind_e   flush_kind_i,
  output ctrl_pkg::redirect_e     redirect_o,
  output ctrl_pkg::flush_kind_e   flush_kind_o,
  output logic                    instr_req_o,
  output logic                    ctrl_busy_o,
  output logic                    first_fetch_o,
  output logic                    is_decoding_o,
  output logic                    halt_if_o,
  output logic                    halt_id_o,
  output logic                    deassert_we_o,
  output logic                    exc_kill_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;
  // flush cause held for the single flush cycle
  ctrl_pkg::flush_kind_e flush_q;

  //////////////////////////////
  // next state and controls
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    redirect_o    = ctrl_pkg::RD_NONE;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_kill_o    = 1'b0;

    case (state_q)
      // out of reset, wait for fetch enable
      ctrl_pkg::RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end

      // load the boot address into the fetch pc
      ctrl_pkg::BOOT_SET: begin
        redirect_o = ctrl_pkg::RD_BOOT;
        state_d    = ctrl_pkg::FIRST_FETCH;
      end

      // one idle cycle before sleeping
      ctrl_pkg::WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end

      ctrl_pkg::SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on fetch enable or any pending interrupt, masked or not
        if (fetch_enable_i || irq_req_i) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end

      ctrl_pkg::FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        // hold while the if stage misses
        if (id_ready_i) begin
          state_d = ctrl_pkg::DECODE;
        end
        // pipe is empty here, so an enabled irq goes straight in
        if (event_i == ctrl_pkg::EV_IRQ) begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = ctrl_pkg::IRQ_TAKEN;
        end
      end

      ctrl_pkg::DECODE: begin
        is_decoding_o = instr_valid_i;
        case (event_i)
          // taken branch and jump redirect in the decode cycle itself
          ctrl_pkg::EV_BRANCH,
          ctrl_pkg::EV_JUMP: begin
            redirect_o = ctrl_pkg::RD_JUMP;
          end
          ctrl_pkg::EV_FLUSH: begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH;
          end
          ctrl_pkg::EV_IRQ: begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::IRQ_TAKEN;
          end
          ctrl_pkg::EV_KILL: begin
            exc_kill_o = 1'b1;
          end
          default: begin
          end
        endcase
      end

      // jump to the irq vector and acknowledge
      ctrl_pkg::IRQ_TAKEN: begin
        redirect_o = ctrl_pkg::RD_IRQ;
        state_d    = ctrl_pkg::DECODE;
      end

      // pipe is flushed, apply the latched cause
      ctrl_pkg::FLUSH: begin
        redirect_o = ctrl_pkg::RD_FLUSH;
        halt_if_o  = ~fetch_enable_i;
        halt_id_o  = 1'b1;
        if (!fetch_enable_i &&
            (flush_q == ctrl_pkg::FL_MRET || flush_q == ctrl_pkg::FL_PIPE)) begin
          state_d = ctrl_pkg::WAIT_SLEEP;
        end else begin
          state_d = ctrl_pkg::DECODE;
        end
      end

      // unused encodings fall back to reset
      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  // no register writes outside decode or for an illegal opcode
  assign deassert_we_o = ~is_decoding_o | illegal_i;

  assign flush_kind_o = flush_q;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ctrl_pkg::RESET;
      flush_q <= ctrl_pkg::FL_ECALL;
    end else begin
      state_q <= state_d;
      // capture the winning cause as the fsm enters flush
      if (state_q == ctrl_pkg::DECODE && event_i == ctrl_pkg::EV_FLUSH) begin
        flush_q <= flush_kind_i;
      end
    end
  end

endmodule

/* hdl/ctrl_trap_encode.sv */
// trap encoder: maps the fsm redirect to pc selects, exception causes and csr strobes
`include "ctrl_params.svh"

module ctrl_trap_encode (
  input  ctrl_pkg::redirect_e          redirect_i,
  input  ctrl_pkg::flush_kind_e        flush_kind_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]    irq_id_i,
  input  ctrl_pkg::priv_lvl_e          m_prv_i,
  output ctrl_pkg::trap_out_t          trap_o
);

  // ecall cause depends on the privilege it was issued from
  logic [`CTRL_CAUSE_W-1:0] ecall_cause;
  // irq cause, top bit marks an interrupt in mcause
  logic [`CTRL_CAUSE_W-1:0] irq_cause;

  assign ecall_cause = `CTRL_CAUSE_W'(`CTRL_CAUSE_ECALL_BASE) | `CTRL_CAUSE_W'(m_prv_i);

  always_comb begin
    irq_cause                   = `CTRL_CAUSE_W'(irq_id_i);
    irq_cause[`CTRL_CAUSE_W-1]  = 1'b1;
  end

  always_comb begin
    trap_o            = '0;
    trap_o.pc_mux     = ctrl_pkg::PC_BOOT;
    trap_o.exc_pc_mux = ctrl_pkg::EXC_PC_IRQ;

    case (redirect_i)
      ctrl_pkg::RD_BOOT: begin
        trap_o.pc_set = 1'b1;
        trap_o.pc_mux = ctrl_pkg::PC_BOOT;
      end

      ctrl_pkg::RD_JUMP: begin
        trap_o.pc_set = 1'b1;
        trap_o.pc_mux = ctrl_pkg::PC_JUMP;
      end

      // save the if pc, id is already halted
      ctrl_pkg::RD_IRQ: begin
        trap_o.pc_set         = 1'b1;
        trap_o.pc_mux         = ctrl_pkg::PC_EXCEPTION;
        trap_o.exc_pc_mux     = ctrl_pkg::EXC_PC_IRQ;
        trap_o.exc_cause      = `CTRL_CAUSE_W'(irq_id_i);
        trap_o.csr_cause      = irq_cause;
        trap_o.csr_save_if    = 1'b1;
        trap_o.csr_save_cause = 1'b1;
        trap_o.irq_ack        = 1'b1;
        trap_o.exc_ack        = 1'b1;
      end

      ctrl_pkg::RD_FLUSH: begin
        case (flush_kind_i)
          // synchronous exceptions save the id pc
          ctrl_pkg::FL_ECALL: begin
            trap_o.pc_set         = 1'b1;
            trap_o.pc_mux         = ctrl_pkg::PC_EXCEPTION;
            trap_o.exc_pc_mux     = ctrl_pkg::EXC_PC_ECALL;
            trap_o.exc_cause      = ecall_cause;
            trap_o.csr_cause      = ecall_cause;
            trap_o.csr_save_id    = 1'b1;
            trap_o.csr_save_cause = 1'b1;
          end
          ctrl_pkg::FL_ILLEGAL: begin
            trap_o.pc_set         = 1'b1;
            trap_o.pc_mux         = ctrl_pkg::PC_EXCEPTION;
            trap_o.exc_pc_mux     = ctrl_pkg::EXC_PC_ILLINSN;
            trap_o.exc_cause      = `CTRL_CAUSE_W'(`CTRL_CAUSE_ILLEGAL);
            trap_o.csr_cause      = `CTRL_CAUSE_W'(`CTRL_CAUSE_ILLEGAL);
            trap_o.csr_save_id    = 1'b1;
            trap_o.csr_save_cause = 1'b1;
          end
          // return to mepc and restore the interrupt enable
          ctrl_pkg::FL_MRET: begin
            trap_o.pc_set           = 1'b1;
            trap_o.pc_mux           = ctrl_pkg::PC_ERET;
            trap_o.csr_restore_mret = 1'b1;
          end
          // cause only, the fetch path is left alone
          ctrl_pkg::FL_EBRK: begin
            trap_o.exc_cause = `CTRL_CAUSE_W'(`CTRL_CAUSE_BREAKPOINT);
          end
          // csr status and pipe flush just drain the pipe
          default: begin
          end
        endcase
      end

      default: begin
      end
    endcase
  end

endmodule

/* hdl/ctrl_top.sv */
// controller top: event classifier, fsm and trap encoder
`include "ctrl_params.svh"

module ctrl_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_enable_i,
  input  logic                       id_ready_i,
  input  logic                       irq_req_i,
  input  logic                       m_ie_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]  irq_id_i,
  input  ctrl_pkg::priv_lvl_e        m_prv_i,
  input  ctrl_pkg::decode_flags_t    decode_i,
  output logic                       instr_req_o,
  output logic                       ctrl_busy_o,
  output logic                       first_fetch_o,
  output logic                       is_decoding_o,
  output logic                       halt_if_o,
  output logic                       halt_id_o,
  output logic                       deassert_we_o,
  output logic                       exc_kill_o,
  output ctrl_pkg::trap_out_t        trap_o,
  output logic [`CTRL_IRQ_ID_W-1:0]  irq_id_o
);

  // classifier to fsm
  ctrl_pkg::decode_event_e event_w;
  ctrl_pkg::flush_kind_e   flush_kind_w;
  // fsm to trap encoder
  ctrl_pkg::redirect_e     redirect_w;
  ctrl_pkg::flush_kind_e   flush_held_w;

  ctrl_event_classify u_classify (
    .decode_i     (decode_i),
    .irq_req_i    (irq_req_i),
    .m_ie_i       (m_ie_i),
    .event_o      (event_w),
    .flush_kind_o (flush_kind_w)
  );

  ctrl_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .id_ready_i     (id_ready_i),
    .irq_req_i      (irq_req_i),
    .instr_valid_i  (decode_i.instr_valid),
    .illegal_i      (decode_i.illegal),
    .event_i        (event_w),
    .flush_kind_i   (flush_kind_w),
    .redirect_o     (redirect_w),
    .flush_kind_o   (flush_held_w),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .deassert_we_o  (deassert_we_o),
    .exc_kill_o     (exc_kill_o)
  );

  ctrl_trap_encode u_trap (
    .redirect_i   (redirect_w),
    .flush_kind_i (flush_held_w),
    .irq_id_i     (irq_id_i),
    .m_prv_i      (m_prv_i),
    .trap_o       (trap_o)
  );

  // id goes back to the interrupt controller with the ack
  assign irq_id_o = irq_id_i;

endmodule

/* bench/ctrl_assertions.sv */
// concurrent checks on controller pc redirect, one-cycle states and interrupt acknowledge
module ctrl_assertions (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  pc_set_i,
  input logic                  busy_i,
  input logic                  irq_ack_i,
  input logic                  exc_ack_i,
  input ctrl_pkg::ctrl_state_e state_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed assertions, read back by the testbench
  int fail_cnt = 0;

  // a pc redirect needs an active controller
  a_pc_set_busy: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> busy_i)
    else begin
      fail_cnt++;
      $error("pc_set raised while ctrl_busy_o is low");
    end

  // flush applies its cause in a single cycle
  a_flush_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == ctrl_pkg::FLUSH |=> state_i != ctrl_pkg::FLUSH)
    else begin
      fail_cnt++;
      $error("FLUSH state held for more than one cycle");
    end

  a_irq_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == ctrl_pkg::IRQ_TAKEN |=> state_i != ctrl_pkg::IRQ_TAKEN)
    else begin
      fail_cnt++;
      $error("IRQ_TAKEN state held for more than one cycle");
    end

  // interrupt ack always comes with the exception ack
  a_ack_pair: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_i |-> exc_ack_i)
    else begin
      fail_cnt++;
      $error("irq_ack high without exc_ack");
    end

endmodule

bind ctrl_top ctrl_assertions u_checks (
  .clk       (clk),
  .rst_n     (rst_n),
  .pc_set_i  (trap_o.pc_set),
  .busy_i    (ctrl_busy_o),
  .irq_ack_i (trap_o.irq_ack),
  .exc_ack_i (trap_o.exc_ack),
  .state_i   (u_fsm.state_q)
);

/* bench/ctrl_tb.sv */
// controller testbench: clock, reset, directed tests, trap reference model and checker
`include "ctrl_params.svh"

module ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED = 32'h4ec7;
  // six tests of at most 40 cycles each, plus margin for reset
  localparam int TEST_COUNT      = 6;
  localparam int TEST_CYCLES_MAX = 40;
  localparam int TIMEOUT_CYCLES  = TEST_COUNT * TEST_CYCLES_MAX + 160;

  logic                         clk;
  logic                         rst_n;
  logic                         fetch_enable;
  logic                         id_ready;
  logic                         irq_req;
  logic                         m_ie;
  logic [`CTRL_IRQ_ID_W-1:0]    irq_id;
  ctrl_pkg::priv_lvl_e          m_prv;
  ctrl_pkg::decode_flags_t      decode;
  logic                         instr_req;
  logic                         ctrl_busy;
  logic                         first_fetch;
  logic                         is_decoding;
  logic                         halt_if;
  logic                         halt_id;
  logic                         deassert_we;
  logic                         exc_kill;
  ctrl_pkg::trap_out_t          trap_o;
  logic [`CTRL_IRQ_ID_W-1:0]    irq_id_echo;

  // redirect the current cycle should show, set by the tests
  ctrl_pkg::redirect_e          exp_rd = ctrl_pkg::RD_NONE;
  ctrl_pkg::flush_kind_e        exp_fk = ctrl_pkg::FL_PIPE;
  ctrl_pkg::trap_out_t          trap_exp;
  ctrl_pkg::trap_out_t          trap_act;

  string       cur_test = "reset";
  int          test_errors = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          checks = 0;
  int          cycle_cnt = 0;

  ctrl_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .id_ready_i     (id_ready),
    .irq_req_i      (irq_req),
    .m_ie_i         (m_ie),
    .irq_id_i       (irq_id),
    .m_prv_i        (m_prv),
    .decode_i       (decode),
    .instr_req_o    (instr_req),
    .ctrl_busy_o    (ctrl_busy),
    .first_fetch_o  (first_fetch),
    .is_decoding_o  (is_decoding),
    .halt_if_o      (halt_if),
    .halt_id_o      (halt_id),
    .deassert_we_o  (deassert_we),
    .exc_kill_o     (exc_kill),
    .trap_o         (trap_o),
    .irq_id_o       (irq_id_echo)
  );

  // 20 ns period
  always #10 clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic ctrl_pkg::trap_out_t expected_trap(
    input ctrl_pkg::redirect_e         rd,
    input ctrl_pkg::flush_kind_e       fk,
    input logic [`CTRL_IRQ_ID_W-1:0]   id,
    input ctrl_pkg::priv_lvl_e         prv
  );
    ctrl_pkg::trap_out_t      t;
    logic [`CTRL_CAUSE_W-1:0] ecall_code;
    t = '0;
    // ecall cause carries the privilege it came from
    ecall_code = `CTRL_CAUSE_W'(`CTRL_CAUSE_ECALL_BASE) | `CTRL_CAUSE_W'(prv);
    case (rd)
      ctrl_pkg::RD_BOOT: begin
        t.pc_set = 1'b1;
        t.pc_mux = ctrl_pkg::PC_BOOT;
      end
      ctrl_pkg::RD_JUMP: begin
        t.pc_set = 1'b1;
        t.pc_mux = ctrl_pkg::PC_JUMP;
      end
      ctrl_pkg::RD_IRQ: begin
        t.pc_set         = 1'b1;
        t.pc_mux         = ctrl_pkg::PC_EXCEPTION;
        t.exc_pc_mux     = ctrl_pkg::EXC_PC_IRQ;
        t.exc_cause      = {1'b0, id};
        // interrupt flag in the top bit of mcause
        t.csr_cause      = {1'b1, id};
        t.csr_save_if    = 1'b1;
        t.csr_save_cause = 1'b1;
        t.irq_ack        = 1'b1;
        t.exc_ack        = 1'b1;
      end
      ctrl_pkg::RD_FLUSH: begin
        if (fk == ctrl_pkg::FL_ECALL || fk == ctrl_pkg::FL_ILLEGAL) begin
          t.pc_set         = 1'b1;
          t.pc_mux         = ctrl_pkg::PC_EXCEPTION;
          t.csr_save_id    = 1'b1;
          t.csr_save_cause = 1'b1;
          if (fk == ctrl_pkg::FL_ECALL) begin
            t.exc_pc_mux = ctrl_pkg::EXC_PC_ECALL;
            t.exc_cause  = ecall_code;
            t.csr_cause  = ecall_code;
          end else begin
            t.exc_pc_mux = ctrl_pkg::EXC_PC_ILLINSN;
            t.exc_cause  = `CTRL_CAUSE_W'(`CTRL_CAUSE_ILLEGAL);
            t.csr_cause  = `CTRL_CAUSE_W'(`CTRL_CAUSE_ILLEGAL);
          end
        end else if (fk == ctrl_pkg::FL_MRET) begin
          t.pc_set           = 1'b1;
          t.pc_mux           = ctrl_pkg::PC_ERET;
          t.csr_restore_mret = 1'b1;
        end else if (fk == ctrl_pkg::FL_EBRK) begin
          t.exc_cause = `CTRL_CAUSE_W'(`CTRL_CAUSE_BREAKPOINT);
        end
      end
      default: begin
      end
    endcase
    return t;
  endfunction

  // selectors are don't care while they steer nothing
  function automatic ctrl_pkg::trap_out_t mask_dont_care(input ctrl_pkg::trap_out_t t);
    ctrl_pkg::trap_out_t m;
    m = t;
    if (!m.pc_set || m.pc_mux != ctrl_pkg::PC_EXCEPTION) begin
      m.exc_pc_mux = ctrl_pkg::EXC_PC_ILLINSN;
    end
    if (!m.pc_set) begin
      m.pc_mux = ctrl_pkg::PC_BOOT;
    end
    return m;
  endfunction

  // trap outputs and id echo compared every cycle once reset is released
  always @(negedge clk) begin
    if (rst_n) begin
      trap_exp = mask_dont_care(expected_trap(exp_rd, exp_fk, irq_id, m_prv));
      trap_act = mask_dont_care(trap_o);
      checks++;
      assert (trap_act === trap_exp) else begin
        $display("CHECK FAILED %s: trap_o expected %h actual %h", cur_test, trap_exp, trap_act);
        test_errors++;
      end
      // id handed back to the interrupt controller unchanged
      checks++;
      assert (irq_id_echo === irq_id) else begin
        $display("CHECK FAILED %s: irq_id_o expected %h actual %h",
                 cur_test, irq_id, irq_id_echo);
        test_errors++;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // outputs are sampled just after the falling edge, behind the per-cycle compare
  task automatic settle();
    @(negedge clk);
    #1;
  endtask

  task automatic expect_level(input string what, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s: %s expected %0b actual %0b", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic close_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, test_errors);
    end
  endtask

  // decoder flags of a plain valid instruction
  function automatic ctrl_pkg::decode_flags_t valid_instr();
    ctrl_pkg::decode_flags_t d;
    d             = '0;
    d.instr_valid = 1'b1;
    return d;
  endfunction

  //////////////////////////////
  // directed tests
  //////////////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    id_ready     = 1'b0;
    irq_req      = 1'b0;
    m_ie         = 1'b0;
    irq_id       = '0;
    m_prv        = ctrl_pkg::PRIV_M;
    decode       = '0;
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // boot from reset into decode
    start_test("boot");
    settle();
    expect_level("instr_req_o", 1'b0, instr_req);
    expect_level("ctrl_busy_o", 1'b0, ctrl_busy);
    next_cycle();
    fetch_enable = 1'b1;
    next_cycle();
    exp_rd = ctrl_pkg::RD_BOOT;
    settle();
    expect_level("pc_set", 1'b1, trap_o.pc_set);
    next_cycle();
    exp_rd = ctrl_pkg::RD_NONE;
    settle();
    expect_level("first_fetch_o", 1'b1, first_fetch);
    expect_level("instr_req_o", 1'b1, instr_req);
    next_cycle();
    // still held without id_ready
    id_ready = 1'b1;
    settle();
    expect_level("first_fetch_o", 1'b1, first_fetch);
    next_cycle();
    decode = valid_instr();
    settle();
    expect_level("is_decoding_o", 1'b1, is_decoding);
    expect_level("deassert_we_o", 1'b0, deassert_we);
    next_cycle();
    decode = '0;
    settle();
    expect_level("is_decoding_o", 1'b0, is_decoding);
    expect_level("deassert_we_o", 1'b1, deassert_we);
    close_test();

    // taken branch then jump, both redirect in the decode cycle
    start_test("branch_jump");
    next_cycle();
    decode            = valid_instr();
    decode.branch_set = 1'b1;
    exp_rd            = ctrl_pkg::RD_JUMP;
    settle();
    expect_level("halt_id_o", 1'b0, halt_id);
    next_cycle();
    decode          = valid_instr();
    decode.jump_set = 1'b1;
    settle();
    expect_level("is_decoding_o", 1'b1, is_decoding);
    next_cycle();
    decode = valid_instr();
    exp_rd = ctrl_pkg::RD_NONE;
    settle();
    expect_level("is_decoding_o", 1'b1, is_decoding);
    close_test();

    // ecall from a random privilege, then illegal instruction
    start_test("ecall_illegal");
    next_cycle();
    m_prv        = ($urandom % 2 != 0) ? ctrl_pkg::PRIV_M : ctrl_pkg::PRIV_U;
    decode       = valid_instr();
    decode.ecall = 1'b1;
    settle();
    expect_level("halt_if_o", 1'b1, halt_if);
    expect_level("halt_id_o", 1'b1, halt_id);
    next_cycle();
    decode = '0;
    exp_rd = ctrl_pkg::RD_FLUSH;
    exp_fk = ctrl_pkg::FL_ECALL;
    settle();
    expect_level("csr_save_id", 1'b1, trap_o.csr_save_id);
    next_cycle();
    decode         = valid_instr();
    decode.illegal = 1'b1;
    exp_rd         = ctrl_pkg::RD_NONE;
    settle();
    expect_level("halt_if_o", 1'b1, halt_if);
    expect_level("deassert_we_o", 1'b1, deassert_we);
    next_cycle();
    decode = '0;
    exp_rd = ctrl_pkg::RD_FLUSH;
    exp_fk = ctrl_pkg::FL_ILLEGAL;
    settle();
    expect_level("csr_save_id", 1'b1, trap_o.csr_save_id);
    next_cycle();
    exp_rd = ctrl_pkg::RD_NONE;
    decode = valid_instr();
    settle();
    expect_level("is_decoding_o", 1'b1, is_decoding);
    close_test();

    // enabled interrupt is taken, masked one only kills
    start_test("interrupt");
    next_cycle();
    irq_id  = `CTRL_IRQ_ID_W'($urandom);
    m_ie    = 1'b1;
    irq_req = 1'b1;
    settle();
    expect_level("halt_if_o", 1'b1, halt_if);
    expect_level("exc_kill_o", 1'b0, exc_kill);
    next_cycle();
    irq_req = 1'b0;
    decode  = '0;
    exp_rd  = ctrl_pkg::RD_IRQ;
    settle();
    expect_level("irq_ack", 1'b1, trap_o.irq_ack);
    next_cycle();
    exp_rd  = ctrl_pkg::RD_NONE;
    irq_id  = `CTRL_IRQ_ID_W'($urandom);
    m_ie    = 1'b0;
    irq_req = 1'b1;
    decode  = valid_instr();
    settle();
    expect_level("exc_kill_o", 1'b1, exc_kill);
    expect_level("halt_if_o", 1'b0, halt_if);
    next_cycle();
    irq_req = 1'b0;
    settle();
    expect_level("irq_ack", 1'b0, trap_o.irq_ack);
    expect_level("is_decoding_o", 1'b1, is_decoding);
    close_test();

    // mret with fetch disabled sleeps, an interrupt request wakes it
    start_test("mret_sleep");
    next_cycle();
    fetch_enable = 1'b0;
    decode       = valid_instr();
    decode.mret  = 1'b1;
    settle();
    expect_level("halt_id_o", 1'b1, halt_id);
    next_cycle();
    decode = '0;
    exp_rd = ctrl_pkg::RD_FLUSH;
    exp_fk = ctrl_pkg::FL_MRET;
    settle();
    expect_level("csr_restore_mret", 1'b1, trap_o.csr_restore_mret);
    next_cycle();
    exp_rd = ctrl_pkg::RD_NONE;
    settle();
    expect_level("ctrl_busy_o", 1'b0, ctrl_busy);
    expect_level("instr_req_o", 1'b0, instr_req);
    next_cycle();
    settle();
    expect_level("halt_if_o", 1'b1, halt_if);
    expect_level("ctrl_busy_o", 1'b0, ctrl_busy);
    next_cycle();
    irq_req = 1'b1;
    settle();
    expect_level("ctrl_busy_o", 1'b0, ctrl_busy);
    next_cycle();
    irq_req      = 1'b0;
    fetch_enable = 1'b1;
    settle();
    expect_level("first_fetch_o", 1'b1, first_fetch);
    expect_level("ctrl_busy_o", 1'b1, ctrl_busy);
    close_test();

    // ebreak reports its cause without a redirect
    start_test("ebreak");
    next_cycle();
    decode      = valid_instr();
    decode.ebrk = 1'b1;
    settle();
    expect_level("halt_if_o", 1'b1, halt_if);
    next_cycle();
    decode = '0;
    exp_rd = ctrl_pkg::RD_FLUSH;
    exp_fk = ctrl_pkg::FL_EBRK;
    settle();
    expect_level("pc_set", 1'b0, trap_o.pc_set);
    next_cycle();
    exp_rd = ctrl_pkg::RD_NONE;
    decode = valid_instr();
    settle();
    expect_level("is_decoding_o", 1'b1, is_decoding);
    close_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, total_errors, dut_i.u_checks.fail_cnt);
    if (total_errors == 0 && dut_i.u_checks.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/ctrl_event_classify.sv
hdl/ctrl_fsm.sv
hdl/ctrl_trap_encode.sv
hdl/ctrl_top.sv
bench/ctrl_assertions.sv
bench/ctrl_tb.sv
